// ==== sim.f ====
verilog/hsdPkg.sv
verilog/gpioRegisters.sv
verilog/bootTimer.sv
verilog/triggerStrobes.sv
verilog/panelInterlock.sv
verilog/hsdControlTop.sv
tb/hsdControl_assertions.sv
tb/hsdControlTb.sv

// ==== Bender.yml ====
package:
  name: hsd_control

sources:
  - verilog/hsdPkg.sv
  - verilog/gpioRegisters.sv
  - verilog/bootTimer.sv
  - verilog/triggerStrobes.sv
  - verilog/panelInterlock.sv
  - verilog/hsdControlTop.sv
  - target: simulation
    files:
      - tb/hsdControl_assertions.sv
      - tb/hsdControlTb.sv

// ==== tb/hsdControlTb.sv ====
module hsdControlTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam hsdPkg::gpioWord buildDateValue = 32'h20240517;

    typedef enum {
        opWrite, opRead, opMark, opDelta, opPanel, opEvr,
        opWait, opClear, opPulses, opLeds, opRelay
    } opCode;

    typedef struct {
        opCode       op;
        int          arg;
        logic [31:0] data;
        logic [31:0] expected;
    } stimRow;

    logic            sysClk;
    logic            rst;
    hsdPkg::regWrite regWr;
    hsdPkg::regAddr  readAddr;
    hsdPkg::evrTrigs evrTriggers;
    logic            pmodResetRecovery;
    logic            pmodDisplay;
    logic            pmodInterlockReset;
    logic            pmodRelayOpen;
    logic            pmodRelayClosed;
    logic            swWest;
    logic            swEast;
    logic            swNorth;
    logic [7:0]      dipSwitch;
    hsdPkg::gpioWord readData;
    hsdPkg::acqTrigs acqStrobes;
    logic            relayControl;
    logic [7:0]      leds;

    stimRow      stimTable[$];
    bit          tableReady = 1'b0;
    int          errorCount = 0;
    integer      seed = 27;
    logic [31:0] markValue;
    int          pulseCount[7];
    int          pulseBase[7];

    hsdControlTop #(
        .clkPerMicrosecond(4),
        .microsecondsPerSecond(20),
        .buildDate(buildDateValue)
    ) dut0 (
        .sysClk(sysClk),
        .rst(rst),
        .regWr(regWr),
        .readAddr(readAddr),
        .evrTriggers(evrTriggers),
        .pmodResetRecovery(pmodResetRecovery),
        .pmodDisplay(pmodDisplay),
        .pmodInterlockReset(pmodInterlockReset),
        .pmodRelayOpen(pmodRelayOpen),
        .pmodRelayClosed(pmodRelayClosed),
        .swWest(swWest),
        .swEast(swEast),
        .swNorth(swNorth),
        .dipSwitch(dipSwitch),
        .readData(readData),
        .acqStrobes(acqStrobes),
        .relayControl(relayControl),
        .leds(leds)
    );

    initial begin
        sysClk = 1'b0;
        forever #5 sysClk = ~sysClk;
    end

    // Strobe counter sees the value settled in the previous cycle
    always @(posedge sysClk) begin
        if (!rst) begin
            for (int i = 0; i < 7; i++) begin
                pulseCount[i] += acqStrobes[i];
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected, input int tolerance);
        if ($isunknown(actual) || actual > expected + tolerance ||
                actual + tolerance < expected) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, actual, expected);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Expected values from the register map
    // Panel input word layout
    //   [7:0]   dip switch
    //   [12:8]  pmod reset recovery, display, button, open, closed
    //   [15:13] sw west, east, north
    function automatic logic [4:0] panelLevels(input logic [31:0] p);
        // Order is reset recovery, display, button, open, closed
        return {!p[12] || p[15], !p[11] || p[14], !p[10] || p[13], !p[9], !p[8]};
    endfunction

    function automatic logic [31:0] userGpioExpected(input logic [31:0] p,
                                                     input logic [5:0] evr);
        logic [4:0]  lv;
        logic [31:0] w;
        lv = panelLevels(p);
        w = '0;
        w[31] = lv[4];
        w[30] = lv[3];
        w[21:16] = evr;
        w[7:0] = p[7:0];
        return w;
    endfunction

    function automatic logic [31:0] interlockExpected(input logic [31:0] p, input logic relay);
        logic [4:0] lv;
        lv = panelLevels(p);
        return {28'h0, lv[0], lv[1], relay, lv[2]};
    endfunction

    function automatic logic [31:0] ledsExpected(input logic [31:0] p, input logic relay);
        logic [4:0] lv;
        lv = panelLevels(p);
        return {24'h0, lv[2], lv[1], lv[0], relay, 4'h0};
    endfunction

    task automatic addRow(input opCode op, input int arg, input logic [31:0] data,
                          input logic [31:0] expected);
        stimTable.push_back('{op, arg, data, expected});
    endtask

    task automatic buildTable();
        logic [5:0]  prevEvr;
        logic [5:0]  pattern;
        logic [31:0] panelA;
        logic [31:0] panelB;
        prevEvr = '0;
        panelA = 32'h0000_4AA5;
        panelB = 32'h0000_151F;
        addRow(opRead, 0, 0, buildDateValue);
        for (int a = 6; a < 16; a++) begin
            addRow(opRead, a, 0, 0);
        end
        // Boot timer runs 4 cycles per microsecond and 20 per second
        addRow(opMark, 1, 0, 0);
        addRow(opWait, 40, 0, 0);
        addRow(opDelta, 1, 1, 10);
        addRow(opMark, 2, 0, 0);
        addRow(opWait, 80, 0, 0);
        addRow(opDelta, 2, 0, 1);
        // Single and reloaded software trigger
        addRow(opClear, 0, 0, 0);
        addRow(opWrite, 3, 1, 0);
        addRow(opPulses, 8, 0, 7'h01);
        addRow(opWait, 8, 0, 0);
        addRow(opClear, 0, 0, 0);
        addRow(opWrite, 3, 1, 0);
        addRow(opWait, 2, 0, 0);
        addRow(opWrite, 3, 1, 0);
        addRow(opPulses, 10, 0, 7'h01);
        // Only rising event lines pulse
        repeat (6) begin
            pattern = 6'($random(seed));
            addRow(opClear, 0, 0, 0);
            addRow(opEvr, 0, pattern, 0);
            addRow(opPulses, 5, 0, {pattern & ~prevEvr, 1'b0});
            addRow(opClear, 0, 0, 0);
            addRow(opPulses, 10, 0, 0);
            prevEvr = pattern;
        end
        // Panel, user GPIO and interlock
        addRow(opPanel, 0, panelA, 0);
        addRow(opWait, 3, 0, 0);
        addRow(opRead, 4, 0, userGpioExpected(panelA, prevEvr));
        addRow(opWrite, 5, 1, 0);
        addRow(opRelay, 0, 0, 1);
        addRow(opLeds, 0, 0, ledsExpected(panelA, 1'b1));
        addRow(opRead, 5, 0, interlockExpected(panelA, 1'b1));
        addRow(opWrite, 5, 0, 0);
        addRow(opRelay, 0, 0, 0);
        addRow(opLeds, 0, 0, ledsExpected(panelA, 1'b0));
        addRow(opRead, 5, 0, interlockExpected(panelA, 1'b0));
        addRow(opPanel, 0, panelB, 0);
        addRow(opWait, 3, 0, 0);
        addRow(opRead, 4, 0, userGpioExpected(panelB, prevEvr));
        addRow(opRead, 5, 0, interlockExpected(panelB, 1'b0));
        addRow(opLeds, 0, 0, ledsExpected(panelB, 1'b0));
    endtask

    //////////////////////////////////////////////////
    // Row execution starts on a falling edge
    task automatic applyRow(input stimRow row);
        case (row.op)
            opWrite: begin
                regWr.strobe = 1'b1;
                regWr.addr = hsdPkg::regAddr'(row.arg);
                regWr.data = row.data;
                @(negedge sysClk);
                regWr.strobe = 1'b0;
            end
            opRead, opMark, opDelta: begin
                readAddr = hsdPkg::regAddr'(row.arg);
                @(negedge sysClk);
                if (row.op == opRead) begin
                    checkValue("readData", readData, row.expected, 0);
                end else if (row.op == opMark) begin
                    markValue = readData;
                end else begin
                    // Data column holds the allowed deviation
                    checkValue("readData delta", readData - markValue, row.expected,
                               int'(row.data));
                end
            end
            opPanel: begin
                dipSwitch = row.data[7:0];
                {pmodResetRecovery, pmodDisplay, pmodInterlockReset} = row.data[12:10];
                {pmodRelayOpen, pmodRelayClosed} = row.data[9:8];
                {swWest, swEast, swNorth} = row.data[15:13];
            end
            opEvr: evrTriggers = row.data[5:0];
            opWait: repeat (row.arg) @(negedge sysClk);
            opClear: pulseBase = pulseCount;
            opPulses: begin
                repeat (row.arg) @(negedge sysClk);
                for (int i = 0; i < 7; i++) begin
                    checkValue($sformatf("acqStrobes[%0d] pulses", i),
                               pulseCount[i] - pulseBase[i], row.expected[i], 0);
                end
            end
            opLeds: checkValue("leds", {24'h0, leds}, row.expected, 0);
            opRelay: checkValue("relayControl", {31'h0, relayControl}, row.expected, 0);
            default: begin
                $display("Unknown operation in the stimulus table");
                errorCount++;
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        regWr = '0;
        readAddr = '0;
        evrTriggers = '0;
        {pmodResetRecovery, pmodDisplay, pmodInterlockReset} = 3'b111;
        {pmodRelayOpen, pmodRelayClosed} = 2'b11;
        {swWest, swEast, swNorth} = 3'b000;
        dipSwitch = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (5) @(posedge sysClk);
        @(negedge sysClk);
        rst = 1'b0;
        foreach (stimTable[i]) begin
            applyRow(stimTable[i]);
        end
        repeat (5) @(negedge sysClk);
        $display("Checks done, %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        longint cycles;
        cycles = 5;
        wait (tableReady);
        foreach (stimTable[i]) begin
            cycles += 2;
            if (stimTable[i].op == opWait || stimTable[i].op == opPulses) begin
                cycles += stimTable[i].arg;
            end
        end
        #((cycles + 200) * 10);
        $display("Timeout, the stimulus table did not finish in %0d cycles", cycles + 200);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== tb/hsdControl_assertions.sv ====
module hsdControl_assertions (
    input logic            sysClk,
    input logic            rst,
    input hsdPkg::regWrite regWr,
    input hsdPkg::regAddr  readAddr,
    input hsdPkg::gpioWord readData,
    input hsdPkg::acqTrigs acqStrobes,
    input logic            relayControl
);

    timeunit 1ns;
    timeprecision 100ps;

    logic relayWrite;

    assign relayWrite = regWr.strobe && (regWr.addr == hsdPkg::addrInterlock);

    // Strobes last a single cycle
    strobeSingleCycle: assert property (@(posedge sysClk) disable iff (rst)
        (acqStrobes & $past(acqStrobes)) == '0)
        else $error("acqStrobes bit high in two consecutive cycles");

    relayOnWriteOnly: assert property (@(posedge sysClk) disable iff (rst)
        (relayControl != $past(relayControl)) |-> $past(relayWrite))
        else $error("relayControl changed without a relay write");

    // Anything above the interlock register is unmapped
    unmappedReadsZero: assert property (@(posedge sysClk) disable iff (rst)
        (readAddr > hsdPkg::addrInterlock) |=> (readData == '0))
        else $error("readData not zero after an unmapped address");

endmodule

bind hsdControlTop hsdControl_assertions asserts0 (
    .sysClk(sysClk),
    .rst(rst),
    .regWr(regWr),
    .readAddr(readAddr),
    .readData(readData),
    .acqStrobes(acqStrobes),
    .relayControl(relayControl)
);

// ==== verilog/hsdControlTop.sv ====
module hsdControlTop #(
    parameter int              clkPerMicrosecond     = 100,
    parameter int              microsecondsPerSecond = 1000000,
    parameter hsdPkg::gpioWord buildDate             = 32'h0
) (
    input  logic            sysClk,
    input  logic            rst,
    input  hsdPkg::regWrite regWr,
    input  hsdPkg::regAddr  readAddr,
    input  hsdPkg::evrTrigs evrTriggers,
    input  logic            pmodResetRecovery,
    input  logic            pmodDisplay,
    input  logic            pmodInterlockReset,
    input  logic            pmodRelayOpen,
    input  logic            pmodRelayClosed,
    input  logic            swWest,
    input  logic            swEast,
    input  logic            swNorth,
    input  logic [7:0]      dipSwitch,
    output hsdPkg::gpioWord readData,
    output hsdPkg::acqTrigs acqStrobes,
    output logic            relayControl,
    output logic [7:0]      leds
);

    hsdPkg::gpioWord    microseconds;
    hsdPkg::gpioWord    seconds;
    hsdPkg::panelStatus status;
    logic               softTriggerStrobe;
    logic               relayWrite;
    logic               relayValue;

    //////////////////////////////////////////////////
    // Register bus
    gpioRegisters #(
        .buildDate(buildDate)
    ) gpioRegisters0 (
        .sysClk(sysClk),
        .rst(rst),
        .regWr(regWr),
        .readAddr(readAddr),
        .microseconds(microseconds),
        .seconds(seconds),
        .evrTriggers(evrTriggers),
        .dipSwitch(dipSwitch),
        .status(status),
        .relayControl(relayControl),
        .readData(readData),
        .softTriggerStrobe(softTriggerStrobe),
        .relayWrite(relayWrite),
        .relayValue(relayValue)
    );

    // Time since boot
    bootTimer #(
        .clkPerMicrosecond(clkPerMicrosecond),
        .microsecondsPerSecond(microsecondsPerSecond)
    ) bootTimer0 (
        .sysClk(sysClk),
        .rst(rst),
        .microseconds(microseconds),
        .seconds(seconds)
    );

    //////////////////////////////////////////////////
    // Triggers and front panel
    triggerStrobes triggerStrobes0 (
        .sysClk(sysClk),
        .rst(rst),
        .softTriggerStrobe(softTriggerStrobe),
        .evrTriggers(evrTriggers),
        .acqStrobes(acqStrobes)
    );

    panelInterlock panelInterlock0 (
        .sysClk(sysClk),
        .rst(rst),
        .pmodResetRecovery(pmodResetRecovery),
        .pmodDisplay(pmodDisplay),
        .pmodInterlockReset(pmodInterlockReset),
        .pmodRelayOpen(pmodRelayOpen),
        .pmodRelayClosed(pmodRelayClosed),
        .swWest(swWest),
        .swEast(swEast),
        .swNorth(swNorth),
        .relayWrite(relayWrite),
        .relayValue(relayValue),
        .status(status),
        .relayControl(relayControl),
        .leds(leds)
    );

endmodule

// ==== verilog/panelInterlock.sv ====
module panelInterlock (
    input  logic               sysClk,
    input  logic               rst,
    input  logic               pmodResetRecovery,
    input  logic               pmodDisplay,
    input  logic               pmodInterlockReset,
    input  logic               pmodRelayOpen,
    input  logic               pmodRelayClosed,
    input  logic               swWest,
    input  logic               swEast,
    input  logic               swNorth,
    input  logic               relayWrite,
    input  logic               relayValue,
    output hsdPkg::panelStatus status,
    output logic               relayControl,
    output logic [7:0]         leds
);

    hsdPkg::panelStatus rawStatus;
    hsdPkg::panelStatus statusMeta;

    //////////////////////////////////////////////////
    // Front panel lines are active low
    // On-board buttons stand in when the panel is absent
    always_comb begin
        rawStatus.resetRecoverySwitch  = !pmodResetRecovery || swWest;
        rawStatus.displaySwitch        = !pmodDisplay || swEast;
        rawStatus.interlockResetButton = !pmodInterlockReset || swNorth;
        rawStatus.relayOpen            = !pmodRelayOpen;
        rawStatus.relayClosed          = !pmodRelayClosed;
    end

    // Two stage synchronizer
    always_ff @(posedge sysClk) begin
        if (rst) begin
            statusMeta <= '0;
            status     <= '0;
        end else begin
            statusMeta <= rawStatus;
            status     <= statusMeta;
        end
    end

    //////////////////////////////////////////////////
    // Interlock relay control register
    always_ff @(posedge sysClk) begin
        if (rst) begin
            relayControl <= 1'b0;
        end else if (relayWrite) begin
            relayControl <= relayValue;
        end
    end

    assign leds = {status.interlockResetButton, status.relayOpen,
                   status.relayClosed, relayControl, 4'b0};

endmodule

// ==== verilog/triggerStrobes.sv ====
module triggerStrobes (
    input  logic            sysClk,
    input  logic            rst,
    input  logic            softTriggerStrobe,
    input  hsdPkg::evrTrigs evrTriggers,
    output hsdPkg::acqTrigs acqStrobes
);

    localparam int stretchWidth = $clog2(hsdPkg::softTriggerStretch + 1);

    logic [stretchWidth-1:0] stretchCount;
    logic                    softTriggerLevel;
    hsdPkg::acqTrigs         combined;
    hsdPkg::acqTrigs         syncMeta;
    hsdPkg::acqTrigs         syncOut;
    hsdPkg::acqTrigs         delayed;
    hsdPkg::acqTrigs         lastDelayed;

    //////////////////////////////////////////////////
    // Software trigger stretcher
    // A write while already high just reloads
    always_ff @(posedge sysClk) begin
        if (rst) begin
            stretchCount <= '0;
        end else if (softTriggerStrobe) begin
            stretchCount <= stretchWidth'(hsdPkg::softTriggerStretch);
        end else if (softTriggerLevel) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    assign softTriggerLevel = (stretchCount != '0);

    // Bit 0 is software, bits 6..1 are event lines 2..7
    assign combined = {evrTriggers, softTriggerLevel};

    //////////////////////////////////////////////////
    // Synchronizer, delay and rising edge detect
    always_ff @(posedge sysClk) begin
        if (rst) begin
            syncMeta    <= '0;
            syncOut     <= '0;
            delayed     <= '0;
            lastDelayed <= '0;
            acqStrobes  <= '0;
        end else begin
            syncMeta    <= combined;
            syncOut     <= syncMeta;
            delayed     <= syncOut;
            lastDelayed <= delayed;
            acqStrobes  <= delayed & ~lastDelayed;
        end
    end

endmodule

// ==== verilog/bootTimer.sv ====
module bootTimer #(
    parameter int clkPerMicrosecond     = 100,
    parameter int microsecondsPerSecond = 1000000
) (
    input  logic            sysClk,
    input  logic            rst,
    output hsdPkg::gpioWord microseconds,
    output hsdPkg::gpioWord seconds
);

    localparam int prescaleWidth = $clog2(clkPerMicrosecond + 1);
    localparam int dividerWidth  = $clog2(microsecondsPerSecond + 1);

    logic [prescaleWidth-1:0] prescaler;
    logic [dividerWidth-1:0]  secondDivider;
    logic                     microTick;
    logic                     secondTick;

    // One cycle tick per microsecond
    assign microTick  = (prescaler == prescaleWidth'(clkPerMicrosecond - 1));
    assign secondTick = microTick &&
                        (secondDivider == dividerWidth'(microsecondsPerSecond - 1));

    always_ff @(posedge sysClk) begin
        if (rst) begin
            prescaler     <= '0;
            secondDivider <= '0;
            microseconds  <= '0;
            seconds       <= '0;
        end else begin
            if (microTick) begin
                prescaler    <= '0;
                microseconds <= microseconds + 1'b1;
            end else begin
                prescaler <= prescaler + 1'b1;
            end
            // Second divider advances on microsecond ticks only
            if (secondTick) begin
                secondDivider <= '0;
                seconds       <= seconds + 1'b1;
            end else if (microTick) begin
                secondDivider <= secondDivider + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/gpioRegisters.sv ====
module gpioRegisters #(
    parameter hsdPkg::gpioWord buildDate = 32'h0
) (
    input  logic               sysClk,
    input  logic               rst,
    input  hsdPkg::regWrite    regWr,
    input  hsdPkg::regAddr     readAddr,
    input  hsdPkg::gpioWord    microseconds,
    input  hsdPkg::gpioWord    seconds,
    input  hsdPkg::evrTrigs    evrTriggers,
    input  logic [7:0]         dipSwitch,
    input  hsdPkg::panelStatus status,
    input  logic               relayControl,
    output hsdPkg::gpioWord    readData,
    output logic               softTriggerStrobe,
    output logic               relayWrite,
    output logic               relayValue
);

    hsdPkg::gpioWord userGpioWord;
    hsdPkg::gpioWord interlockWord;

    //////////////////////////////////////////////////
    // Write decode
    // Strobes are combinational so the target
    // register updates on the next edge
    always_comb begin
        softTriggerStrobe = regWr.strobe && (regWr.addr == hsdPkg::addrSoftTrigger);
        relayWrite        = regWr.strobe && (regWr.addr == hsdPkg::addrInterlock);
    end

    assign relayValue = regWr.data[0];

    //////////////////////////////////////////////////
    // Status words
    always_comb begin
        userGpioWord = '0;
        userGpioWord[hsdPkg::userGpioResetBit]   = status.resetRecoverySwitch;
        userGpioWord[hsdPkg::userGpioDisplayBit] = status.displaySwitch;
        userGpioWord[hsdPkg::userGpioEvrLsb +: $bits(hsdPkg::evrTrigs)] = evrTriggers;
        // Board serial number switch
        userGpioWord[hsdPkg::userGpioDipLsb +: 8] = dipSwitch;
    end

    always_comb begin
        interlockWord = '0;
        interlockWord[hsdPkg::interlockClosedBit] = status.relayClosed;
        interlockWord[hsdPkg::interlockOpenBit]   = status.relayOpen;
        interlockWord[hsdPkg::interlockRelayBit]  = relayControl;
        interlockWord[hsdPkg::interlockButtonBit] = status.interlockResetButton;
    end

    //////////////////////////////////////////////////
    // Registered readback
    // Unmapped addresses read as zero
    always_ff @(posedge sysClk) begin
        if (rst) begin
            readData <= '0;
        end else begin
            case (readAddr)
                hsdPkg::addrBuildDate: begin
                    readData <= buildDate;
                end
                hsdPkg::addrMicroseconds: begin
                    readData <= microseconds;
                end
                hsdPkg::addrSeconds: begin
                    readData <= seconds;
                end
                hsdPkg::addrUserGpio: begin
                    readData <= userGpioWord;
                end
                hsdPkg::addrInterlock: begin
                    readData <= interlockWord;
                end
                default: begin
                    readData <= '0;
                end
            endcase
        end
    end

endmodule

// ==== verilog/hsdPkg.sv ====
package hsdPkg;

    //////////////////////////////////////////////////
    // Data path types
    typedef logic [31:0] gpioWord;
    typedef logic [3:0]  regAddr;

    // Event trigger lines 2..7 and the acquisition strobe bus
    typedef logic [5:0] evrTrigs;
    typedef logic [6:0] acqTrigs;

    // One register bus write, strobe qualifies the cycle
    typedef struct packed {
        logic    strobe;
        regAddr  addr;
        gpioWord data;
    } regWrite;

    // Synchronized front panel and relay levels
    typedef struct packed {
        logic resetRecoverySwitch;
        logic displaySwitch;
        logic interlockResetButton;
        logic relayOpen;
        logic relayClosed;
    } panelStatus;

    //////////////////////////////////////////////////
    // Register map
    localparam regAddr addrBuildDate    = 4'd0;
    localparam regAddr addrMicroseconds = 4'd1;
    localparam regAddr addrSeconds      = 4'd2;
    localparam regAddr addrSoftTrigger  = 4'd3;
    localparam regAddr addrUserGpio     = 4'd4;
    localparam regAddr addrInterlock    = 4'd5;

    // Status word bit positions
    localparam int userGpioResetBit   = 31;
    localparam int userGpioDisplayBit = 30;
    localparam int userGpioEvrLsb     = 16;
    localparam int userGpioDipLsb     = 0;
    localparam int interlockClosedBit = 3;
    localparam int interlockOpenBit   = 2;
    localparam int interlockRelayBit  = 1;
    localparam int interlockButtonBit = 0;

    // Cycles the stretched software trigger stays high
    localparam int softTriggerStretch = 8;

endpackage
